// File: design/mem_sp.sv
`timescale 1ns/1ps
`include "renkon_defs.svh"

module mem_sp #(
  parameter int DW = `RENKON_DWIDTH,
  parameter int AW = $clog2(`RENKON_MAXSIZE)
) (
  input  logic          clk,
  input  logic          mem_we,
  input  logic [AW-1:0] mem_addr,
  input  logic [DW-1:0] mem_wdata,
  output logic [DW-1:0] mem_rdata
);

  logic [DW-1:0] mem [2**AW];

  // registered read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule

// File: design/renkon_conv_top.sv
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_conv_top (
  input  logic               clk,
  input  logic               xrst,
  input  logic               wt_we,
  input  renkon_pkg::waddr_t wt_addr,
  input  renkon_pkg::pixel_t wt_data,
  input  logic               buf_en,
  input  renkon_pkg::size_t  img_size,
  input  renkon_pkg::size_t  fil_size,
  input  renkon_pkg::pixel_t pix_in,
  output logic               out_valid,
  output renkon_pkg::pixel_t out_data,
  output logic               done
);

  renkon_pkg::pixel_t [`RENKON_MAXLINE*`RENKON_MAXLINE-1:0] window;
  logic       win_valid;
  logic       lb_done;
  logic [1:0] r_done_d;

  renkon_linebuf u_linebuf (
    .clk       (clk),
    .xrst      (xrst),
    .buf_en    (buf_en),
    .img_size  (img_size),
    .fil_size  (fil_size),
    .buf_input (pix_in),
    .window    (window),
    .win_valid (win_valid),
    .done      (lb_done)
  );

  renkon_conv_tree u_conv_tree (
    .clk       (clk),
    .xrst      (xrst),
    .wt_we     (wt_we),
    .wt_addr   (wt_addr),
    .wt_data   (wt_data),
    .window    (window),
    .win_valid (win_valid),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  // done follows the two pipeline stages so it lands after the last result
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_done_d <= '0;
    end else begin
      r_done_d <= {r_done_d[0], lb_done};
    end
  end

  assign done = r_done_d[1];

endmodule

// File: design/renkon_conv_tree.sv
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_conv_tree (
  input  logic                                                     clk,
  input  logic                                                     xrst,
  input  logic                                                     wt_we,
  input  renkon_pkg::waddr_t                                       wt_addr,
  input  renkon_pkg::pixel_t                                       wt_data,
  input  renkon_pkg::pixel_t [`RENKON_MAXLINE*`RENKON_MAXLINE-1:0] window,
  input  logic                                                     win_valid,
  output logic                                                     out_valid,
  output renkon_pkg::pixel_t                                       out_data
);

  localparam int NW = `RENKON_MAXLINE * `RENKON_MAXLINE;
  localparam renkon_pkg::acc_t SAT_MAX = renkon_pkg::acc_t'((1 << (`RENKON_DWIDTH - 1)) - 1);
  localparam renkon_pkg::acc_t SAT_MIN = -SAT_MAX - 1;

  renkon_pkg::pixel_t r_weight [NW];
  renkon_pkg::acc_t   r_prod [NW];
  renkon_pkg::acc_t   sum;
  renkon_pkg::acc_t   shifted;
  renkon_pkg::acc_t   sat;
  logic               r_prod_valid;

  always_ff @(posedge clk) begin
    if (wt_we && wt_addr < renkon_pkg::waddr_t'(NW)) begin
      r_weight[wt_addr] <= wt_data;
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    for (int i = 0; i < NW; i++) begin
      r_prod[i] <= $signed(window[i]) * r_weight[i];
    end
  end

  // adder tree over all products, unused taps carry zero weight
  always_comb begin
    sum = '0;
    for (int i = 0; i < NW; i++) begin
      sum = sum + r_prod[i];
    end
  end

  // back to pixel scale, clamp to the pixel range
  always_comb begin
    shifted = sum >>> `RENKON_FRAC;
    if (shifted > SAT_MAX) begin
      sat = SAT_MAX;
    end else if (shifted < SAT_MIN) begin
      sat = SAT_MIN;
    end else begin
      sat = shifted;
    end
  end

  // stage 2
  always_ff @(posedge clk) begin
    out_data <= renkon_pkg::pixel_t'(sat);
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_prod_valid <= 1'b0;
      out_valid    <= 1'b0;
    end else begin
      r_prod_valid <= win_valid;
      out_valid    <= r_prod_valid;
    end
  end

endmodule

// File: design/renkon_linebuf.sv
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_linebuf (
  input  logic                                                     clk,
  input  logic                                                     xrst,
  input  logic                                                     buf_en,
  input  renkon_pkg::size_t                                        img_size,
  input  renkon_pkg::size_t                                        fil_size,
  input  renkon_pkg::pixel_t                                       buf_input,
  output renkon_pkg::pixel_t [`RENKON_MAXLINE*`RENKON_MAXLINE-1:0] window,
  output logic                                                     win_valid,
  output logic                                                     done
);

  localparam int ML = `RENKON_MAXLINE;
  localparam int NMEM = ML + 1;
  localparam int AW = $clog2(`RENKON_MAXSIZE);
  localparam int MW = $clog2(NMEM);

  renkon_pkg::lb_state_t r_state;
  renkon_pkg::size_t     r_addr_count;
  renkon_pkg::size_t     r_line_count;
  logic [MW-1:0]         r_mem_count;
  logic [MW-1:0]         r_select;

  logic running;
  logic row_end;
  logic charge_end;
  logic active_end;
  logic col_ok;
  logic r_valid_d1;
  logic r_end_d1;
  logic r_end_d2;

  renkon_pkg::pixel_t r_pix_d;
  renkon_pkg::pixel_t read_mem [NMEM];
  renkon_pkg::pixel_t col_in [ML];
  renkon_pkg::pixel_t r_pixel [ML][ML];

  assign running = r_state != renkon_pkg::S_WAIT;
  assign row_end = running && r_addr_count == img_size - 1'b1;

  // charge holds the first fil_size-1 rows, the next row completes a footprint
  assign charge_end = r_state == renkon_pkg::S_CHARGE && row_end
                      && r_line_count == fil_size - 2'd2;
  assign active_end = r_state == renkon_pkg::S_ACTIVE && row_end
                      && r_line_count == img_size - 1'b1;
  assign col_ok = r_state == renkon_pkg::S_ACTIVE
                  && r_addr_count >= fil_size - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= renkon_pkg::S_WAIT;
    end else begin
      case (r_state)
        renkon_pkg::S_WAIT: begin
          if (buf_en) begin
            r_state <= (fil_size > 1'b1) ? renkon_pkg::S_CHARGE : renkon_pkg::S_ACTIVE;
          end
        end
        renkon_pkg::S_CHARGE: begin
          if (charge_end) begin
            r_state <= renkon_pkg::S_ACTIVE;
          end
        end
        renkon_pkg::S_ACTIVE: begin
          if (active_end) begin
            r_state <= renkon_pkg::S_WAIT;
          end
        end
        default: begin
          r_state <= renkon_pkg::S_WAIT;
        end
      endcase
    end
  end

  // row r of the frame lands in memory r mod NMEM
  always_ff @(posedge clk) begin
    if (!xrst || !running) begin
      r_addr_count <= '0;
      r_line_count <= '0;
      r_mem_count  <= '0;
    end else if (row_end) begin
      r_addr_count <= '0;
      r_line_count <= r_line_count + 1'b1;
      r_mem_count  <= (r_mem_count == MW'(ML)) ? '0 : r_mem_count + 1'b1;
    end else begin
      r_addr_count <= r_addr_count + 1'b1;
    end
  end

  // one stage for the memory read, one for the window load
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_select   <= '0;
      r_valid_d1 <= 1'b0;
      win_valid  <= 1'b0;
      r_end_d1   <= 1'b0;
      r_end_d2   <= 1'b0;
      done       <= 1'b0;
    end else begin
      r_select   <= r_mem_count;
      r_valid_d1 <= col_ok;
      win_valid  <= r_valid_d1;
      r_end_d1   <= active_end;
      r_end_d2   <= r_end_d1;
      done       <= r_end_d2;
    end
  end

  // current row bypasses its memory, aligned with the read data
  always_ff @(posedge clk) begin
    r_pix_d <= buf_input;
  end

  for (genvar m = 0; m < NMEM; m++) begin : g_mem
    mem_sp #(
      .DW(`RENKON_DWIDTH),
      .AW(AW)
    ) u_mem (
      .clk       (clk),
      .mem_we    (running && r_mem_count == MW'(m)),
      .mem_addr  (r_addr_count[AW-1:0]),
      .mem_wdata (buf_input),
      .mem_rdata (read_mem[m])
    );
  end

  // window row i takes the row fil_size-1-i lines back from the current one
  always_comb begin
    int k;
    int idx;
    for (int i = 0; i < ML; i++) begin
      k = int'(fil_size) - 1 - i;
      idx = int'(r_select) - k;
      if (idx < 0) begin
        idx = idx + NMEM;
      end
      if (k == 0) begin
        col_in[i] = r_pix_d;
      end else if (k > 0 && k < NMEM) begin
        col_in[i] = read_mem[idx];
      end else begin
        col_in[i] = '0;
      end
    end
  end

  // new column enters on the right and the window shifts left
  always_ff @(posedge clk) begin
    for (int i = 0; i < ML; i++) begin
      for (int j = 0; j < ML - 1; j++) begin
        r_pixel[i][j] <= r_pixel[i][j+1];
      end
      r_pixel[i][ML-1] <= col_in[i];
    end
  end

  // move the footprint to the top-left corner to line up with the weights
  always_comb begin
    int off;
    off = ML - int'(fil_size);
    for (int i = 0; i < ML; i++) begin
      for (int j = 0; j < ML; j++) begin
        if (i < int'(fil_size) && j < int'(fil_size) && j + off >= 0) begin
          window[i*ML+j] = r_pixel[i][j+off];
        end else begin
          window[i*ML+j] = '0;
        end
      end
    end
  end

endmodule

// File: design/renkon_pkg.sv
`include "renkon_defs.svh"

package renkon_pkg;

  // pixels, weights and results share one signed fixed-point format
  typedef logic signed [`RENKON_DWIDTH-1:0] pixel_t;

  // products and sums, with headroom for all 25 terms
  typedef logic signed [2*`RENKON_DWIDTH+4:0] acc_t;

  typedef logic [`RENKON_LWIDTH-1:0] size_t;

  // row-major index into the weight array
  typedef logic [$clog2(`RENKON_MAXLINE*`RENKON_MAXLINE)-1:0] waddr_t;

  // charge fills the first rows, active issues windows
  typedef enum logic [1:0] {
    S_WAIT,
    S_CHARGE,
    S_ACTIVE
  } lb_state_t;

endpackage

// File: include/renkon_defs.svh
`ifndef RENKON_DEFS_SVH
`define RENKON_DEFS_SVH

// pixel and weight width
`define RENKON_DWIDTH 16

// fractional bits of pixels and weights
`define RENKON_FRAC 8

// width of the img_size and fil_size inputs
`define RENKON_LWIDTH 8

// largest filter side, also the window side
`define RENKON_MAXLINE 5

// largest image side, sets the depth of each row memory
`define RENKON_MAXSIZE 32

`endif

// File: run.sh
#!/bin/sh
# build with Verilator, run, then decide from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module renkon_conv_tb -f tb.f -o renkon_sim \
  && ./obj_dir/renkon_sim > sim.log 2>&1 \
  || echo "build or simulation stopped early"
grep -q "Test completed successfully" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: tb.f
+incdir+include
design/renkon_pkg.sv
design/mem_sp.sv
design/renkon_linebuf.sv
design/renkon_conv_tree.sv
design/renkon_conv_top.sv
tests/renkon_clkgen.sv
tests/renkon_conv_tb.sv

// File: tests/renkon_clkgen.sv
`timescale 1ns/1ps

module renkon_clkgen #(
  parameter int PERIOD = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    xrst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    xrst = 1'b1;
  end

endmodule

// File: tests/renkon_conv_tb.sv
`timescale 1ns/1ps
`include "renkon_defs.svh"

module renkon_conv_tb;

  localparam int ML = `RENKON_MAXLINE;
  localparam int PERIOD = 40;

  logic               clk;
  logic               por_xrst;
  logic               tb_xrst;
  logic               xrst;
  logic               wt_we;
  renkon_pkg::waddr_t wt_addr;
  renkon_pkg::pixel_t wt_data;
  logic               buf_en;
  renkon_pkg::size_t  img_size;
  renkon_pkg::size_t  fil_size;
  renkon_pkg::pixel_t pix_in;
  logic               out_valid;
  renkon_pkg::pixel_t out_data;
  logic               done;

  renkon_pkg::pixel_t img [`RENKON_MAXSIZE*`RENKON_MAXSIZE];
  renkon_pkg::pixel_t wts [ML*ML];
  int   cur_img;
  int   cur_fil;
  int   out_count;
  int   frames_done;
  int   frames_started;
  int   mismatch_count;
  int   fail_count;
  logic frame_open;

  assign xrst = por_xrst & tb_xrst;

  renkon_clkgen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) u_clkgen (.clk(clk), .xrst(por_xrst));

  renkon_conv_top DUT (
    .clk       (clk),
    .xrst      (xrst),
    .wt_we     (wt_we),
    .wt_addr   (wt_addr),
    .wt_data   (wt_data),
    .buf_en    (buf_en),
    .img_size  (img_size),
    .fil_size  (fil_size),
    .pix_in    (pix_in),
    .out_valid (out_valid),
    .out_data  (out_data),
    .done      (done)
  );

  // window n of the frame, weights sit in the top-left corner of the 5x5 array
  function automatic int conv_ref(input int n);
    int w;
    int r;
    int c;
    longint acc;
    w = cur_img - cur_fil + 1;
    r = n / w;
    c = n % w;
    acc = 0;
    for (int i = 0; i < cur_fil; i++) begin
      for (int j = 0; j < cur_fil; j++) begin
        acc += longint'(img[(r + i) * cur_img + c + j]) * longint'(wts[i * ML + j]);
      end
    end
    acc = acc >>> `RENKON_FRAC;
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    return int'(acc);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  function automatic void random_image(input int n, input int lo, input int hi);
    for (int k = 0; k < n * n; k++) begin
      img[k] = renkon_pkg::pixel_t'(rand_range(lo, hi));
    end
  endfunction

  function automatic void random_weights(input int fil, input int lo, input int hi);
    for (int a = 0; a < ML * ML; a++) begin
      if (a / ML < fil && a % ML < fil) begin
        wts[a] = renkon_pkg::pixel_t'(rand_range(lo, hi));
      end else begin
        wts[a] = '0;
      end
    end
  endfunction

  task automatic load_weights();
    for (int a = 0; a < ML * ML; a++) begin
      @(posedge clk);
      #1;
      wt_we = 1'b1;
      wt_addr = renkon_pkg::waddr_t'(a);
      wt_data = wts[a];
    end
    @(posedge clk);
    #1;
    wt_we = 1'b0;
  endtask

  // buf_en strobe, then pixel 0 on the next cycle
  task automatic start_frame(input int n, input int fil);
    cur_img = n;
    cur_fil = fil;
    frame_open = 1'b1;
    @(posedge clk);
    #1;
    img_size = renkon_pkg::size_t'(n);
    fil_size = renkon_pkg::size_t'(fil);
    buf_en = 1'b1;
    @(posedge clk);
    #1;
    buf_en = 1'b0;
    pix_in = img[0];
  endtask

  task automatic feed_pixels(input int first, input int last);
    for (int k = first; k <= last; k++) begin
      @(posedge clk);
      #1;
      pix_in = img[k];
    end
  endtask

  task automatic run_frame(input int n, input int fil);
    frames_started++;
    start_frame(n, fil);
    feed_pixels(1, n * n - 1);
    wait (frames_done == frames_started);
    frame_open = 1'b0;
  endtask

  always @(negedge clk) begin
    logic signed [31:0] got;
    int expv;
    int w;
    got = out_data;
    if (!xrst) begin
      out_count = 0;
    end else begin
      if (out_valid) begin
        if (!frame_open) begin
          fail_count++;
          $display("%0t ns: out_valid pulsed while no frame was running", $time);
        end else begin
          expv = conv_ref(out_count);
          if (got !== expv) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: out_data expected %0d, got %0d", $time, expv, got);
          end
        end
        out_count++;
      end
      if (done) begin
        w = cur_img - cur_fil + 1;
        if (!frame_open) begin
          fail_count++;
          $display("%0t ns: done pulsed while no frame was running", $time);
        end else if (out_count != w * w) begin
          fail_count++;
          $display("%0t ns: frame ended with %0d results instead of %0d", $time, out_count,
                   w * w);
        end
        frames_done++;
        out_count = 0;
      end
    end
  end

  // budget per frame is side squared plus 4 sides plus 50 cycles
  initial begin
    int sizes [7];
    longint cycles;
    sizes = '{8, 12, 16, 10, 6, 8, 8};
    cycles = 0;
    foreach (sizes[i]) begin
      cycles += sizes[i] * sizes[i] + 4 * sizes[i] + 50;
    end
    #(cycles * PERIOD);
    fail_count++;
    $display("timeout after %0d cycles, a frame never finished", cycles);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(79156));
    tb_xrst = 1'b1;
    wt_we = 1'b0;
    wt_addr = '0;
    wt_data = '0;
    buf_en = 1'b0;
    img_size = 8'd8;
    fil_size = 8'd3;
    pix_in = '0;
    frame_open = 1'b0;
    out_count = 0;
    frames_done = 0;
    frames_started = 0;
    mismatch_count = 0;
    fail_count = 0;
    wait (por_xrst);

    repeat (10) begin
      @(negedge clk);
      if (out_valid || done) begin
        fail_count++;
        $display("%0t ns: output active while idle after reset", $time);
      end
    end

    // ramp through an identity kernel, results equal the interior
    for (int k = 0; k < 64; k++) begin
      img[k] = renkon_pkg::pixel_t'(k * 16);
    end
    random_weights(0, 0, 0);
    wts[ML + 1] = renkon_pkg::pixel_t'(1 << `RENKON_FRAC);
    load_weights();
    run_frame(8, 3);

    random_image(12, -512, 511);
    random_weights(5, -128, 127);
    load_weights();
    run_frame(12, 5);

    // top half drives positive saturation, bottom half negative
    for (int k = 0; k < 256; k++) begin
      img[k] = renkon_pkg::pixel_t'((k < 128) ? rand_range(16384, 32767)
                                              : rand_range(-32768, -16384));
    end
    random_weights(3, 4096, 32767);
    load_weights();
    run_frame(16, 3);

    random_image(10, -1024, 1023);
    random_weights(4, -96, 96);
    load_weights();
    run_frame(10, 4);
    random_image(6, -1024, 1023);
    random_weights(2, -300, 300);
    load_weights();
    run_frame(6, 2);

    // reset in the middle of a frame
    random_image(8, -1024, 1023);
    random_weights(3, -200, 200);
    load_weights();
    start_frame(8, 3);
    feed_pixels(1, 39);
    tb_xrst = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (out_valid || done) begin
      fail_count++;
      $display("%0t ns: outputs still active during mid-frame reset", $time);
    end
    @(posedge clk);
    #1;
    tb_xrst = 1'b1;
    frame_open = 1'b0;
    random_image(8, -1024, 1023);
    run_frame(8, 3);

    repeat (10) @(posedge clk);
    if (frames_done != 6) begin
      fail_count++;
      $display("done pulsed %0d times over 6 complete frames", frames_done);
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
